/* src/audio_codec_pkg.sv */
//========================================
// audio codec bridge shared definitions
// sample widths, codec bus address, setup
// register table and the word types used
// between the setup and bus blocks
//========================================
package audio_codec_pkg;

   localparam int SAMPLE_W = 24;
   localparam int CFG_COUNT = 10;

   // 7-bit address 0x1a with the write bit
   localparam logic [7:0] CODEC_ADDR_BYTE = 8'h34;

   typedef logic signed [SAMPLE_W-1:0] audio_sample_t;

   typedef struct packed {
      audio_sample_t left;
      audio_sample_t right;
   } stereo_sample_t;

   // bus order, first byte on top
   typedef struct packed {
      logic [7:0] reg_byte;
      logic [7:0] data_byte;
   } codec_bytes_t;

   // codec register view
   typedef struct packed {
      logic [6:0] reg_addr;
      logic [8:0] ctrl_data;
   } codec_fields_t;

   typedef union packed {
      codec_bytes_t  bytes;
      codec_fields_t fields;
   } codec_word_u;

   //========================================
   // setup writes, issued in table order
   //========================================
   localparam codec_word_u CFG_TABLE [CFG_COUNT] = '{
      16'h0017,   // left line in
      16'h0217,   // right line in
      16'h0479,   // left headphone out
      16'h0679,   // right headphone out
      16'h0810,   // analogue path
      16'h0a06,   // digital path
      16'h0c00,   // power down control
      16'h0e4a,   // master, i2s, 24 bit
      16'h1000,   // sampling control
      16'h1201    // activate
   };

endpackage

/* src/codec_setup_seq.sv */
//========================================
// codec setup sequencer
// on a rising edge of aud_en walks the
// register table, one bus write per entry
//========================================
module codec_setup_seq #(
   parameter int SETUP_GAP = 256
) (
   input  logic                         rstn,
   input  logic                         aud_bclk,
   input  logic                         aud_en,
   input  logic                         busy,
   output logic                         cfg_start,
   output audio_codec_pkg::codec_word_u cfg_word
);
   import audio_codec_pkg::*;

   localparam int IDX_W = $clog2(CFG_COUNT);
   localparam int GAP_W = $clog2(SETUP_GAP);

   localparam logic [2:0] ST_IDLE      = 3'd0;
   localparam logic [2:0] ST_ISSUE     = 3'd1;
   localparam logic [2:0] ST_WAIT_ACK  = 3'd2;
   localparam logic [2:0] ST_WAIT_DONE = 3'd3;
   localparam logic [2:0] ST_GAP       = 3'd4;

   logic             en_meta;
   logic             en_sync;
   logic             en_prev;
   logic             en_rise;
   logic [2:0]       state;
   logic [IDX_W-1:0] idx;
   logic [GAP_W-1:0] gap_cnt;

   assign en_rise = en_sync & ~en_prev;

   always_ff @(posedge aud_bclk or negedge rstn)
   begin
      if (!rstn)
      begin
         en_meta   <= 1'b0;
         en_sync   <= 1'b0;
         en_prev   <= 1'b0;
         state     <= ST_IDLE;
         idx       <= '0;
         gap_cnt   <= '0;
         cfg_start <= 1'b0;
      end
      else
      begin
         en_meta   <= aud_en;
         en_sync   <= en_meta;
         en_prev   <= en_sync;
         cfg_start <= 1'b0;
         case (state)
            ST_IDLE:
            begin
               idx <= '0;
               if (en_rise)
                  state <= ST_ISSUE;
            end
            ST_ISSUE:
            begin
               cfg_start <= 1'b1;
               state     <= ST_WAIT_ACK;
            end
            ST_WAIT_ACK:
            begin
               if (busy)   // engine took the word
                  state <= ST_WAIT_DONE;
            end
            ST_WAIT_DONE:
            begin
               if (!busy)
               begin
                  gap_cnt <= '0;
                  idx     <= idx + 1'b1;
                  if (idx == IDX_W'(CFG_COUNT - 1))
                     state <= ST_IDLE;
                  else
                     state <= ST_GAP;
               end
            end
            ST_GAP:
            begin
               gap_cnt <= gap_cnt + 1'b1;
               if (gap_cnt == GAP_W'(SETUP_GAP - 2))
                  state <= ST_ISSUE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // word is filled through the register view
   always_ff @(posedge aud_bclk)
   begin
      if (state == ST_ISSUE)
         cfg_word.fields <= CFG_TABLE[idx].fields;
   end

endmodule

/* src/i2c_write_engine.sv */
//========================================
// two-wire bus write engine
// sends address, register and data bytes
// as one frame with start and stop, all
// ack slots driven low
//========================================
module i2c_write_engine #(
   parameter int I2C_TICK_DIV = 64
) (
   input  logic                         rstn,
   input  logic                         aud_bclk,
   input  logic                         cfg_start,
   input  audio_codec_pkg::codec_word_u cfg_word,
   output logic                         busy,
   output logic                         aud_sclk,
   output logic                         aud_sdin
);
   import audio_codec_pkg::*;

   localparam int DIV_W = (I2C_TICK_DIV > 1) ? $clog2(I2C_TICK_DIV) : 1;
   localparam int FRAME_BITS = 27;   // three bytes, three acks

   // tick 0 start, 1..54 bit slots, 55 stop low, 56 stop high
   localparam logic [5:0] STOP_LOW  = 6'd55;
   localparam logic [5:0] LAST_TICK = 6'd56;

   logic [DIV_W-1:0]      div_cnt;
   logic                  tick;
   logic [5:0]            tick_idx;
   logic [5:0]            next_idx;
   logic                  slot_low;
   logic                  load;
   logic [FRAME_BITS-1:0] frame_sr;

   assign load     = cfg_start & ~busy;
   assign tick     = busy && (div_cnt == DIV_W'(I2C_TICK_DIV - 1));
   assign next_idx = tick_idx + 6'd1;
   assign slot_low = tick && next_idx[0] && (next_idx < STOP_LOW);

   //========================================
   // tick divider
   //========================================
   always_ff @(posedge aud_bclk or negedge rstn)
   begin
      if (!rstn)
         div_cnt <= '0;
      else if (!busy || tick)
         div_cnt <= '0;
      else
         div_cnt <= div_cnt + 1'b1;
   end

   //========================================
   // frame phases
   //========================================
   always_ff @(posedge aud_bclk or negedge rstn)
   begin
      if (!rstn)
      begin
         busy     <= 1'b0;
         tick_idx <= '0;
         aud_sclk <= 1'b1;
         aud_sdin <= 1'b1;
      end
      else if (load)
      begin
         busy     <= 1'b1;
         tick_idx <= '0;
         aud_sdin <= 1'b0;   // start, sclk stays high
      end
      else if (tick)
      begin
         if (tick_idx == LAST_TICK)
         begin
            busy     <= 1'b0;
            aud_sdin <= 1'b1;   // stop
         end
         else
         begin
            tick_idx <= next_idx;
            if (next_idx == STOP_LOW)
            begin
               aud_sclk <= 1'b0;
               aud_sdin <= 1'b0;
            end
            else if (slot_low)
            begin
               aud_sclk <= 1'b0;
               aud_sdin <= frame_sr[FRAME_BITS-1];
            end
            else
               aud_sclk <= 1'b1;
         end
      end
   end

   always_ff @(posedge aud_bclk)
   begin
      if (load)
         frame_sr <= {CODEC_ADDR_BYTE, 1'b0,
                      cfg_word.bytes.reg_byte, 1'b0,
                      cfg_word.bytes.data_byte, 1'b0};
      else if (slot_low)
         frame_sr <= {frame_sr[FRAME_BITS-2:0], 1'b0};   // msb first
   end

   // sequencer must wait for the frame to finish
   a_no_start_while_busy: assert property (@(posedge aud_bclk) disable iff (!rstn)
      cfg_start |-> !busy);

   // data moves under a high clock only for start and stop
   a_sdin_stable_high: assert property (@(posedge aud_bclk) disable iff (!rstn)
      ($changed(aud_sdin) && aud_sclk && $past(aud_sclk))
         |-> (busy && tick_idx == 6'd0) || !busy);

endmodule

/* src/i2s_capture.sv */
//========================================
// i2s adc capture
// shifts in 24-bit left and right words
// after each word-clock edge
//========================================
module i2s_capture (
   input  logic                            rstn,
   input  logic                            aud_bclk,
   input  logic                            aud_adclrc,
   input  logic                            aud_adcdat,
   output audio_codec_pkg::stereo_sample_t captured
);
   import audio_codec_pkg::*;

   localparam logic [4:0] LAST_BIT = 5'(SAMPLE_W - 1);

   logic          lrc_prev;
   logic          lrc_edge;
   logic          active;
   logic          right_ch;
   logic          word_done;
   logic          store;
   logic [4:0]    bit_cnt;
   audio_sample_t shift_word;

   assign lrc_edge = aud_adclrc ^ lrc_prev;

   always_ff @(posedge aud_bclk or negedge rstn)
   begin
      if (!rstn)
      begin
         lrc_prev  <= 1'b0;
         active    <= 1'b0;
         right_ch  <= 1'b0;
         word_done <= 1'b0;
         store     <= 1'b0;
         bit_cnt   <= '0;
      end
      else
      begin
         lrc_prev  <= aud_adclrc;
         word_done <= 1'b0;
         store     <= word_done;
         if (lrc_edge)
         begin
            active   <= 1'b1;
            bit_cnt  <= '0;
            right_ch <= aud_adclrc;   // high level is the right slot
         end
         else if (active)
         begin
            if (bit_cnt == LAST_BIT)
            begin
               active    <= 1'b0;
               word_done <= 1'b1;
            end
            else
               bit_cnt <= bit_cnt + 1'b1;
         end
      end
   end

   // one shifter, slots never overlap
   always_ff @(posedge aud_bclk)
   begin
      if (active)
         shift_word <= {shift_word[SAMPLE_W-2:0], aud_adcdat};
   end

   always_ff @(posedge aud_bclk or negedge rstn)
   begin
      if (!rstn)
         captured <= '0;
      else if (store)
      begin
         if (right_ch)
            captured.right <= shift_word;
         else
            captured.left <= shift_word;
      end
   end

   a_bit_cnt_range: assert property (@(posedge aud_bclk) disable iff (!rstn)
      bit_cnt <= LAST_BIT);

endmodule

/* src/i2s_playback.sv */
//========================================
// i2s dac playback
// sends the stored word of each channel,
// data changes on the falling bit clock
//========================================
module i2s_playback (
   input  logic                            rstn,
   input  logic                            aud_bclk,
   input  logic                            aud_daclrc,
   input  audio_codec_pkg::stereo_sample_t captured,
   output logic                            aud_dacdat
);
   import audio_codec_pkg::*;

   localparam logic [4:0] LAST_BIT = 5'(SAMPLE_W - 1);

   logic          lrc_prev;
   logic          lrc_edge;
   logic          active;
   logic [4:0]    bit_cnt;
   audio_sample_t shift_word;

   assign lrc_edge = aud_daclrc ^ lrc_prev;

   always_ff @(posedge aud_bclk or negedge rstn)
   begin
      if (!rstn)
      begin
         lrc_prev <= 1'b0;
         active   <= 1'b0;
         bit_cnt  <= '0;
      end
      else
      begin
         lrc_prev <= aud_daclrc;
         if (lrc_edge)
         begin
            active  <= 1'b1;
            bit_cnt <= '0;
         end
         else if (active)
         begin
            if (bit_cnt == LAST_BIT)
               active <= 1'b0;
            else
               bit_cnt <= bit_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge aud_bclk)
   begin
      if (lrc_edge)
         shift_word <= aud_daclrc ? captured.right : captured.left;
      else if (active)
         shift_word <= {shift_word[SAMPLE_W-2:0], 1'b0};
   end

   always_ff @(negedge aud_bclk or negedge rstn)
   begin
      if (!rstn)
         aud_dacdat <= 1'b0;
      else if (active)
         aud_dacdat <= shift_word[SAMPLE_W-1];   // holds between slots
   end

   // word clock must not cut a slot short
   a_load_at_slot_start: assert property (@(posedge aud_bclk) disable iff (!rstn)
      lrc_edge |-> !active || bit_cnt == LAST_BIT);

endmodule

/* src/audio_codec_top.sv */
//========================================
// audio codec bridge top level
// codec setup over the two-wire bus and
// line-in to line-out i2s loopback
//========================================
module audio_codec_top #(
   parameter int I2C_TICK_DIV = 64,
   parameter int SETUP_GAP    = 256
) (
   input  logic rstn,
   input  logic aud_bclk,
   input  logic aud_en,
   input  logic aud_adclrc,
   input  logic aud_adcdat,
   input  logic aud_daclrc,
   output logic aud_sclk,
   output logic aud_sdin,
   output logic aud_dacdat
);
   import audio_codec_pkg::*;

   logic           cfg_start;
   logic           busy;
   codec_word_u    cfg_word;
   stereo_sample_t captured;

   //========================================
   // codec setup
   //========================================
   codec_setup_seq #(
      .SETUP_GAP (SETUP_GAP)
   ) codec_setup_seq_i (
      .rstn      (rstn),
      .aud_bclk  (aud_bclk),
      .aud_en    (aud_en),
      .busy      (busy),
      .cfg_start (cfg_start),
      .cfg_word  (cfg_word)
   );

   i2c_write_engine #(
      .I2C_TICK_DIV (I2C_TICK_DIV)
   ) i2c_write_engine_i (
      .rstn      (rstn),
      .aud_bclk  (aud_bclk),
      .cfg_start (cfg_start),
      .cfg_word  (cfg_word),
      .busy      (busy),
      .aud_sclk  (aud_sclk),
      .aud_sdin  (aud_sdin)
   );

   //========================================
   // audio loopback
   //========================================
   i2s_capture i2s_capture_i (
      .rstn       (rstn),
      .aud_bclk   (aud_bclk),
      .aud_adclrc (aud_adclrc),
      .aud_adcdat (aud_adcdat),
      .captured   (captured)
   );

   i2s_playback i2s_playback_i (
      .rstn       (rstn),
      .aud_bclk   (aud_bclk),
      .aud_daclrc (aud_daclrc),
      .captured   (captured),
      .aud_dacdat (aud_dacdat)
   );

endmodule

/* verification/tb_audio_codec_top.sv */
//========================================
// testbench for the audio codec bridge
// checks the setup writes on the two-wire
// bus and the i2s line-in to line-out loop
//========================================
module tb_audio_codec_top;
   import audio_codec_pkg::*;

   localparam int TICK_DIV     = 4;
   localparam int GAP_CYCLES   = 16;
   localparam int N_FRAMES     = 8;
   localparam int SLOT_CYCLES  = 32;   // half of a 64 cycle frame
   localparam int FRAME_TICKS  = 56;
   localparam int TIMEOUT_CYCLES = CFG_COUNT * FRAME_TICKS * TICK_DIV
      + CFG_COUNT * GAP_CYCLES + N_FRAMES * 2 * SLOT_CYCLES + 200;

   // 7-bit codec address 0x1a followed by the write bit
   localparam logic [7:0] ADDR_BYTE_EXP = {7'h1a, 1'b0};

   // data byte of each setup write in register order
   localparam logic [7:0] CFG_DATA_EXP [CFG_COUNT] = '{
      8'h17, 8'h17, 8'h79, 8'h79, 8'h10, 8'h06, 8'h00, 8'h4a, 8'h00, 8'h01
   };

   typedef struct packed {
      stereo_sample_t din;
      stereo_sample_t dout;
   } loop_row_t;

   logic rstn;
   logic aud_bclk;
   logic aud_en;
   logic aud_adclrc;
   logic aud_adcdat;
   logic aud_daclrc;
   logic aud_sclk;
   logic aud_sdin;
   logic aud_dacdat;

   loop_row_t   stim_table [N_FRAMES];
   logic [15:0] lfsr_state = 16'd74;
   int          cycle_cnt = 0;
   int          idle_errors = 0;
   int          audio_errors = 0;
   int          setup_errors = 0;
   int          bus_errors = 0;

   // bus frame decoder state
   logic        prev_sclk = 1'b1;
   logic        prev_sdin = 1'b1;
   logic        in_frame = 1'b0;
   logic [27:0] frame_bits = '0;   // 27 bit slots and the stop low slot
   int          frame_bit_cnt = 0;
   int          frames_seen = 0;

   audio_codec_top #(
      .I2C_TICK_DIV (TICK_DIV),
      .SETUP_GAP    (GAP_CYCLES)
   ) audio_codec_top_i (
      .rstn       (rstn),
      .aud_bclk   (aud_bclk),
      .aud_en     (aud_en),
      .aud_adclrc (aud_adclrc),
      .aud_adcdat (aud_adcdat),
      .aud_daclrc (aud_daclrc),
      .aud_sclk   (aud_sclk),
      .aud_sdin   (aud_sdin),
      .aud_dacdat (aud_dacdat)
   );

   initial
   begin
      aud_bclk = 1'b0;
      forever #20 aud_bclk = ~aud_bclk;
   end

   //========================================
   // helpers
   //========================================
   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic draw_word(output audio_sample_t w);
      int b;
      w = '0;
      for (b = 0; b < SAMPLE_W; b++)
      begin
         lfsr_state = lfsr_step(lfsr_state);   // one step per bit
         w = {w[SAMPLE_W-2:0], lfsr_state[0]};
      end
   endtask

   task automatic print_error_counts();
      $display("errors: idle %0d, bus %0d, setup %0d, audio %0d, bus frames seen %0d",
               idle_errors, bus_errors, setup_errors, audio_errors, frames_seen);
   endtask

   task automatic check_idle_bit(input string sig, input logic got, input logic exp);
      assert (got === exp)
      else
      begin
         idle_errors++;
         $display("error at %0t: %s expected %b got %b", $time, sig, exp, got);
      end
   endtask

   // one i2s slot on both word clocks
   task automatic play_slot(input logic lrc_level, input audio_sample_t din,
                            input audio_sample_t dout, input string slot_name,
                            input int frame);
      audio_sample_t din_sr;
      audio_sample_t played;
      int            c;
      din_sr = din;
      played = '0;
      for (c = 0; c < SLOT_CYCLES; c++)
      begin
         @(posedge aud_bclk);
         #5;
         if (c == 0)
         begin
            aud_adclrc = lrc_level;
            aud_daclrc = lrc_level;
         end
         if (c >= 1 && c <= SAMPLE_W)
         begin
            aud_adcdat = din_sr[SAMPLE_W-1];   // msb first
            din_sr = din_sr << 1;
         end
         else
            aud_adcdat = 1'b0;
         if (c >= 2 && c <= SAMPLE_W + 1)
            played = {played[SAMPLE_W-2:0], aud_dacdat};
      end
      assert (played === dout)
      else
      begin
         audio_errors++;
         $display("error at %0t: aud_dacdat %s word of frame %0d expected %h got %h",
                  $time, slot_name, frame, dout, played);
      end
   endtask

   task automatic check_bus_frame();
      logic [7:0] exp_reg;
      exp_reg = {7'(frames_seen), 1'b0};
      assert (frame_bit_cnt == 28)
      else
      begin
         bus_errors++;
         $display("bus frame %0d had %0d clock pulses instead of 28", frames_seen,
                  frame_bit_cnt);
      end
      assert (frame_bits[27:20] === ADDR_BYTE_EXP)
      else
      begin
         bus_errors++;
         $display("error at %0t: aud_sdin address byte of frame %0d expected %h got %h",
                  $time, frames_seen, ADDR_BYTE_EXP, frame_bits[27:20]);
      end
      assert (frame_bits[18:11] === exp_reg)
      else
      begin
         bus_errors++;
         $display("error at %0t: aud_sdin register byte of frame %0d expected %h got %h",
                  $time, frames_seen, exp_reg, frame_bits[18:11]);
      end
      assert (frame_bits[9:2] === CFG_DATA_EXP[frames_seen])
      else
      begin
         bus_errors++;
         $display("error at %0t: aud_sdin data byte of frame %0d expected %h got %h",
                  $time, frames_seen, CFG_DATA_EXP[frames_seen], frame_bits[9:2]);
      end
      assert ({frame_bits[19], frame_bits[10], frame_bits[1]} === 3'b000)
      else
      begin
         bus_errors++;
         $display("error at %0t: aud_sdin ack slots of frame %0d expected 000 got %b",
                  $time, frames_seen, {frame_bits[19], frame_bits[10], frame_bits[1]});
      end
   endtask

   //========================================
   // bus frame decoder
   //========================================
   always @(negedge aud_bclk)
   begin
      if (rstn)
      begin
         if (prev_sclk && aud_sclk && prev_sdin && !aud_sdin)
         begin
            assert (!in_frame)
            else
            begin
               bus_errors++;
               $display("start condition seen inside bus frame %0d at %0t",
                        frames_seen, $time);
            end
            assert (frames_seen < CFG_COUNT)
            else
            begin
               bus_errors++;
               $display("more bus frames started than setup writes at %0t", $time);
            end
            in_frame = 1'b1;
            frame_bit_cnt = 0;
         end
         else if (prev_sclk && aud_sclk && !prev_sdin && aud_sdin)
         begin
            if (in_frame && frames_seen < CFG_COUNT)
               check_bus_frame();
            else
            begin
               bus_errors++;
               $display("stop condition seen outside a bus frame at %0t", $time);
            end
            in_frame = 1'b0;
            frames_seen++;
         end
         else if (!prev_sclk && aud_sclk && in_frame)
         begin
            frame_bits = {frame_bits[26:0], aud_sdin};   // sample on rising sclk
            frame_bit_cnt++;
         end
      end
      prev_sclk = aud_sclk;
      prev_sdin = aud_sdin;
   end

   // watchdog
   always @(posedge aud_bclk)
   begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
         print_error_counts();
         $display("Test failures found");
         $finish;
      end
   end

   //========================================
   // main sequence
   //========================================
   initial
   begin
      audio_sample_t w;
      int            n;
      rstn = 1'b0;
      aud_en = 1'b0;
      aud_adclrc = 1'b0;
      aud_adcdat = 1'b0;
      aud_daclrc = 1'b0;
      for (n = 0; n < N_FRAMES; n++)
      begin
         draw_word(w);
         stim_table[n].din.left = w;
         draw_word(w);
         stim_table[n].din.right = w;
         // playback lags capture by one frame
         stim_table[n].dout.left  = (n == 0) ? '0 : stim_table[n-1].din.left;
         stim_table[n].dout.right = (n == 0) ? '0 : stim_table[n-1].din.right;
      end

      repeat (8) @(posedge aud_bclk);
      #5;
      rstn = 1'b1;
      repeat (8)
      begin
         @(posedge aud_bclk);
         #5;
         check_idle_bit("aud_sclk", aud_sclk, 1'b1);
         check_idle_bit("aud_sdin", aud_sdin, 1'b1);
         check_idle_bit("aud_dacdat", aud_dacdat, 1'b0);
      end

      fork
         begin
            @(posedge aud_bclk);
            #5;
            aud_en = 1'b1;
            wait (frames_seen == CFG_COUNT);
            repeat (4 * GAP_CYCLES) @(posedge aud_bclk);   // no eleventh write
            assert (frames_seen == CFG_COUNT && !in_frame)
            else
            begin
               setup_errors++;
               $display("bus activity continued after the last setup write");
            end
         end
         begin
            // lead-in right slot so frame 0 opens on a falling word clock
            play_slot(1'b1, '0, '0, "lead-in right", -1);
            for (n = 0; n < N_FRAMES; n++)
            begin
               play_slot(1'b0, stim_table[n].din.left, stim_table[n].dout.left,
                         "left", n);
               play_slot(1'b1, stim_table[n].din.right, stim_table[n].dout.right,
                         "right", n);
            end
         end
      join

      print_error_counts();
      if (idle_errors + bus_errors + setup_errors + audio_errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

/* audio_codec_top.f */
src/audio_codec_pkg.sv
src/codec_setup_seq.sv
src/i2c_write_engine.sv
src/i2s_capture.sv
src/i2s_playback.sv
src/audio_codec_top.sv
verification/tb_audio_codec_top.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --assert -j 0 --top-module tb_audio_codec_top -f audio_codec_top.f
	out="$$(./obj_dir/Vtb_audio_codec_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
